// ==== include/mp64_settings.svh ====
/*
 * Shared constants of the Megapad-64 interconnect: core count, bus widths,
 * peripheral map and system-information values. Included by the package and the RTL.
 */
`ifndef MP64_SETTINGS_SVH
`define MP64_SETTINGS_SVH

// ====================
// Cores and widths
// ====================
`define MP64_NUM_CORES      4
`define MP64_CORE_ID_BITS   2
`define MP64_TILE_ADDR_BITS 20
`define MP64_TILE_DATA_BITS 512
`define MP64_MMIO_ADDR_BITS 12
`define MP64_CSR_ADDR_BITS  8
`define MP64_XLEN           64

// CSR addresses caught for the mailbox
`define MP64_CSR_MBOX       8'h22
`define MP64_CSR_IPIACK     8'h23

// ====================
// Peripheral map
// ====================
// Region code lives in MMIO address bits 11..8
`define MP64_REGION_UART     4'h0
`define MP64_REGION_TIMER    4'h1
`define MP64_REGION_DISK     4'h2
`define MP64_REGION_SYSINFO  4'h3
`define MP64_REGION_NIC      4'h4
`define MP64_REGION_MBOX     4'h5
`define MP64_REGION_SPINLOCK 4'h6

// System information answers
`define MP64_SYSINFO_ID     64'h4D50_3634_0002_0001
`define MP64_RAM_BYTES      64'd1048576

`endif

// ==== rtl/mp64_pkg.sv ====
/*
 * Types shared by the interconnect RTL and its testbench.
 * Import with a wildcard in the module header.
 */
`include "mp64_settings.svh"

package mp64_pkg;

    // ====================
    // Core indexing
    // ====================
    // Index of one core
    typedef logic [`MP64_CORE_ID_BITS-1:0] core_id_t;
    // One bit per core, bit c belongs to core c
    typedef logic [`MP64_NUM_CORES-1:0] core_mask_t;

    // ====================
    // Bus fields
    // ====================
    // Tile port A, one 512-bit line per address
    typedef logic [`MP64_TILE_ADDR_BITS-1:0] tile_addr_t;
    typedef logic [`MP64_TILE_DATA_BITS-1:0] tile_data_t;

    // Peripheral window offset
    typedef logic [`MP64_MMIO_ADDR_BITS-1:0] mmio_addr_t;
    // CSR number as issued by the CPU
    typedef logic [`MP64_CSR_ADDR_BITS-1:0] csr_addr_t;

    typedef logic [`MP64_XLEN-1:0] xword_t;
    typedef logic [7:0] byte_t;

    // Tile arbiter FSM
    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_t;

endpackage

// ==== rtl/tile_port_arbiter.sv ====
/*
 * Round-robin arbiter that shares the 512-bit memory port A among the tile engines.
 * A grant is held from load until the memory acknowledges.
 */
`timescale 1ns/1ps
`include "mp64_settings.svh"

module tile_port_arbiter
    import mp64_pkg::*;
(
    input  logic                               sys_clk,
    input  logic                               sys_rst_n,

    // Tile engine side, one lane per core
    input  core_mask_t                         tile_req,
    input  tile_addr_t [`MP64_NUM_CORES-1:0]   tile_addr,
    input  core_mask_t                         tile_wen,
    input  tile_data_t [`MP64_NUM_CORES-1:0]   tile_wdata,
    output core_mask_t                         tile_ack,

    // Shared memory port A
    output logic                               mem_tile_req,
    output tile_addr_t                         mem_tile_addr,
    output logic                               mem_tile_wen,
    output tile_data_t                         mem_tile_wdata,
    input  logic                               mem_tile_ack
);

    arb_state_t state;
    core_id_t   grant;
    core_id_t   last_grant;
    core_id_t   next_grant;
    logic       any_req;

    // ====================
    // Round-robin scan
    // ====================
    // Start right after the last winner, the last winner itself comes last
    always_comb begin
        core_id_t cand;
        logic     found;
        cand       = last_grant;
        found      = 1'b0;
        next_grant = last_grant;
        for (int i = 1; i <= `MP64_NUM_CORES; i++) begin
            cand = last_grant + core_id_t'(i);
            if (!found && tile_req[cand]) begin
                next_grant = cand;
                found      = 1'b1;
            end
        end
    end

    assign any_req = |tile_req;

    // ====================
    // Grant FSM
    // ====================
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state      <= ARB_IDLE;
            grant      <= '0;
            last_grant <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    // Load the winner, the port is requested from the next cycle
                    if (any_req) begin
                        grant <= next_grant;
                        state <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    // Memory latency is open ended, the ack cycle closes it
                    if (mem_tile_ack) begin
                        last_grant <= grant;
                        state      <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // ====================
    // Shared port drive
    // ====================
    // Request comes from the registered state only, so the address is already valid
    assign mem_tile_req   = (state == ARB_BUSY);
    assign mem_tile_addr  = tile_addr[grant];
    assign mem_tile_wen   = (state == ARB_BUSY) && tile_wen[grant];
    assign mem_tile_wdata = tile_wdata[grant];

    // Acknowledge goes back to the winner only
    always_comb begin
        tile_ack = '0;
        if (state == ARB_BUSY) begin
            tile_ack[grant] = mem_tile_ack;
        end
    end

    // ====================
    // Assertions
    // ====================
    // Winner must not move while the memory is working on its access
    a_grant_stable: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        (state == ARB_BUSY) |=> (grant == $past(grant))
    ) else $error("tile arbiter grant changed while busy");

    a_ack_onehot: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        $onehot0(tile_ack)
    ) else $error("more than one tile_ack bit high");

    // Memory may only answer a request that the arbiter has raised
    a_no_ack_idle: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        (state == ARB_IDLE) |-> !mem_tile_ack
    ) else $error("mem_tile_ack seen with no request outstanding");

endmodule

// ==== rtl/mmio_decoder.sv ====
/*
 * Decodes the peripheral window into selects and returns the selected read byte.
 * Also answers the system-information registers. Fully combinational.
 */
`timescale 1ns/1ps
`include "mp64_settings.svh"

module mmio_decoder
    import mp64_pkg::*;
(
    input  logic       mmio_req,
    input  mmio_addr_t mmio_addr,

    // Read bytes from the peripherals
    input  byte_t      uart_rdata,
    input  byte_t      timer_rdata,
    input  byte_t      disk_rdata,
    input  byte_t      nic_rdata,
    input  byte_t      mbox_rdata,

    // One-hot peripheral selects
    output logic       uart_sel,
    output logic       timer_sel,
    output logic       disk_sel,
    output logic       nic_sel,
    output logic       mbox_sel,

    output xword_t     mmio_rdata
);

    logic [3:0] region;
    logic       sysinfo_sel;
    xword_t     sysinfo_rdata;

    // Region code in the top nibble
    assign region = mmio_addr[11:8];

    // ====================
    // Region decode
    // ====================
    always_comb begin
        uart_sel    = mmio_req && (region == `MP64_REGION_UART);
        timer_sel   = mmio_req && (region == `MP64_REGION_TIMER);
        disk_sel    = mmio_req && (region == `MP64_REGION_DISK);
        sysinfo_sel = mmio_req && (region == `MP64_REGION_SYSINFO);
        nic_sel     = mmio_req && (region == `MP64_REGION_NIC);
        // Mailbox block also serves the spinlocks
        mbox_sel    = mmio_req && ((region == `MP64_REGION_MBOX) ||
                                   (region == `MP64_REGION_SPINLOCK));
    end

    // ====================
    // System information
    // ====================
    // Offset taken from the low address byte
    always_comb begin
        case (mmio_addr[7:0])
            8'h00:   sysinfo_rdata = `MP64_SYSINFO_ID;
            8'h08:   sysinfo_rdata = `MP64_RAM_BYTES;
            8'h10:   sysinfo_rdata = xword_t'(`MP64_NUM_CORES);
            default: sysinfo_rdata = '0;
        endcase
    end

    // ====================
    // Read multiplexer
    // ====================
    // Peripheral bytes are zero-extended, no select gives 0
    always_comb begin
        mmio_rdata = '0;
        if (uart_sel) begin
            mmio_rdata = xword_t'(uart_rdata);
        end else if (timer_sel) begin
            mmio_rdata = xword_t'(timer_rdata);
        end else if (disk_sel) begin
            mmio_rdata = xword_t'(disk_rdata);
        end else if (nic_sel) begin
            mmio_rdata = xword_t'(nic_rdata);
        end else if (mbox_sel) begin
            mmio_rdata = xword_t'(mbox_rdata);
        end else if (sysinfo_sel) begin
            mmio_rdata = sysinfo_rdata;
        end
    end

    // Priority in the mux above relies on at most one select
    always_comb begin
        a_sel_onehot: assert ($onehot0({uart_sel, timer_sel, disk_sel,
                                        sysinfo_sel, nic_sel, mbox_sel}))
            else $error("peripheral selects not one-hot");
    end

endmodule

// ==== rtl/csr_ipi_router.sv ====
/*
 * Per-core CSR steering: mailbox and IPI-acknowledge writes go to the mailbox,
 * and the CSR read data comes from the mailbox or the tile engine.
 */
`timescale 1ns/1ps
`include "mp64_settings.svh"

module csr_ipi_router
    import mp64_pkg::*;
(
    // From the CPU
    input  logic      csr_wen,
    input  csr_addr_t csr_addr,

    // Read sources
    input  xword_t    tile_csr_rdata,
    input  xword_t    mbox_csr_rdata,

    // Write strobe into the mailbox CSR port
    output logic      mbox_csr_wen,
    // Back to the CPU
    output xword_t    csr_rdata
);

    logic mbox_hit;

    // ====================
    // Address match
    // ====================
    // Only these two CSRs belong to the mailbox
    assign mbox_hit = (csr_addr == `MP64_CSR_MBOX) ||
                      (csr_addr == `MP64_CSR_IPIACK);

    // Tile engine still sees every write on its own csr_wen
    assign mbox_csr_wen = csr_wen && mbox_hit;

    // ====================
    // Read select
    // ====================
    // Same address test picks the read source
    always_comb begin
        if (mbox_hit) begin
            csr_rdata = mbox_csr_rdata;
        end else begin
            csr_rdata = tile_csr_rdata;
        end
    end

endmodule

// ==== rtl/mp64_fabric.sv ====
/*
 * Shared interconnect top: tile port arbiter, peripheral decoder and one
 * CSR router per core. CPUs, tile engines, memory and peripherals attach at the ports.
 */
`timescale 1ns/1ps
`include "mp64_settings.svh"

module mp64_fabric
    import mp64_pkg::*;
(
    input  logic                               sys_clk,
    input  logic                               sys_rst_n,

    // ====================
    // Tile engines
    // ====================
    input  core_mask_t                         tile_req,
    input  tile_addr_t [`MP64_NUM_CORES-1:0]   tile_addr,
    input  core_mask_t                         tile_wen,
    input  tile_data_t [`MP64_NUM_CORES-1:0]   tile_wdata,
    output core_mask_t                         tile_ack,

    // Memory port A
    output logic                               mem_tile_req,
    output tile_addr_t                         mem_tile_addr,
    output logic                               mem_tile_wen,
    output tile_data_t                         mem_tile_wdata,
    input  logic                               mem_tile_ack,

    // ====================
    // Peripheral window
    // ====================
    input  logic                               mmio_req,
    input  mmio_addr_t                         mmio_addr,
    input  byte_t                              uart_rdata,
    input  byte_t                              timer_rdata,
    input  byte_t                              disk_rdata,
    input  byte_t                              nic_rdata,
    input  byte_t                              mbox_rdata,
    output logic                               uart_sel,
    output logic                               timer_sel,
    output logic                               disk_sel,
    output logic                               nic_sel,
    output logic                               mbox_sel,
    output xword_t                             mmio_rdata,

    // ====================
    // Per-core CSR
    // ====================
    input  core_mask_t                         csr_wen,
    input  csr_addr_t  [`MP64_NUM_CORES-1:0]   csr_addr,
    input  xword_t     [`MP64_NUM_CORES-1:0]   tile_csr_rdata,
    input  xword_t     [`MP64_NUM_CORES-1:0]   mbox_csr_rdata,
    output core_mask_t                         mbox_csr_wen,
    output xword_t     [`MP64_NUM_CORES-1:0]   csr_rdata
);

    // Port A arbitration across the tile engines
    tile_port_arbiter tile_port_arbiter_inst (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .tile_req       (tile_req),
        .tile_addr      (tile_addr),
        .tile_wen       (tile_wen),
        .tile_wdata     (tile_wdata),
        .tile_ack       (tile_ack),
        .mem_tile_req   (mem_tile_req),
        .mem_tile_addr  (mem_tile_addr),
        .mem_tile_wen   (mem_tile_wen),
        .mem_tile_wdata (mem_tile_wdata),
        .mem_tile_ack   (mem_tile_ack)
    );

    // Peripheral selects and read path
    mmio_decoder mmio_decoder_inst (
        .mmio_req    (mmio_req),
        .mmio_addr   (mmio_addr),
        .uart_rdata  (uart_rdata),
        .timer_rdata (timer_rdata),
        .disk_rdata  (disk_rdata),
        .nic_rdata   (nic_rdata),
        .mbox_rdata  (mbox_rdata),
        .uart_sel    (uart_sel),
        .timer_sel   (timer_sel),
        .disk_sel    (disk_sel),
        .nic_sel     (nic_sel),
        .mbox_sel    (mbox_sel),
        .mmio_rdata  (mmio_rdata)
    );

    // One router per core, each with its own lane
    genvar c;
    generate
        for (c = 0; c < `MP64_NUM_CORES; c++) begin : g_router
            csr_ipi_router csr_ipi_router_inst (
                .csr_wen        (csr_wen[c]),
                .csr_addr       (csr_addr[c]),
                .tile_csr_rdata (tile_csr_rdata[c]),
                .mbox_csr_rdata (mbox_csr_rdata[c]),
                .mbox_csr_wen   (mbox_csr_wen[c]),
                .csr_rdata      (csr_rdata[c])
            );
        end
    endgenerate

endmodule

// ==== testbench/tb_mp64_fabric.sv ====
/*
 * Testbench for the interconnect top. Reads commands from the input file, models the
 * port A memory responder and checks arbitration, peripheral decode and CSR routing.
 */
`timescale 1ns/1ps
`include "mp64_settings.svh"

module tb_mp64_fabric
    import mp64_pkg::*;
();

    // ====================
    // DUT signals
    // ====================
    logic                               sys_clk;
    logic                               sys_rst_n;
    core_mask_t                         tile_req;
    tile_addr_t [`MP64_NUM_CORES-1:0]   tile_addr;
    core_mask_t                         tile_wen;
    tile_data_t [`MP64_NUM_CORES-1:0]   tile_wdata;
    core_mask_t                         tile_ack;
    logic                               mem_tile_req;
    tile_addr_t                         mem_tile_addr;
    logic                               mem_tile_wen;
    tile_data_t                         mem_tile_wdata;
    logic                               mem_tile_ack;
    logic                               mmio_req;
    mmio_addr_t                         mmio_addr;
    byte_t                              uart_rdata;
    byte_t                              timer_rdata;
    byte_t                              disk_rdata;
    byte_t                              nic_rdata;
    byte_t                              mbox_rdata;
    logic                               uart_sel;
    logic                               timer_sel;
    logic                               disk_sel;
    logic                               nic_sel;
    logic                               mbox_sel;
    xword_t                             mmio_rdata;
    core_mask_t                         csr_wen;
    csr_addr_t  [`MP64_NUM_CORES-1:0]   csr_addr;
    xword_t     [`MP64_NUM_CORES-1:0]   tile_csr_rdata;
    xword_t     [`MP64_NUM_CORES-1:0]   mbox_csr_rdata;
    core_mask_t                         mbox_csr_wen;
    xword_t     [`MP64_NUM_CORES-1:0]   csr_rdata;

    // Bookkeeping
    int    errors      = 0;
    int    checks      = 0;
    int    cycles      = 0;
    int    cycle_limit = 0;
    string cmds[$];

    mp64_fabric mp64_fabric_inst (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .tile_req       (tile_req),
        .tile_addr      (tile_addr),
        .tile_wen       (tile_wen),
        .tile_wdata     (tile_wdata),
        .tile_ack       (tile_ack),
        .mem_tile_req   (mem_tile_req),
        .mem_tile_addr  (mem_tile_addr),
        .mem_tile_wen   (mem_tile_wen),
        .mem_tile_wdata (mem_tile_wdata),
        .mem_tile_ack   (mem_tile_ack),
        .mmio_req       (mmio_req),
        .mmio_addr      (mmio_addr),
        .uart_rdata     (uart_rdata),
        .timer_rdata    (timer_rdata),
        .disk_rdata     (disk_rdata),
        .nic_rdata      (nic_rdata),
        .mbox_rdata     (mbox_rdata),
        .uart_sel       (uart_sel),
        .timer_sel      (timer_sel),
        .disk_sel       (disk_sel),
        .nic_sel        (nic_sel),
        .mbox_sel       (mbox_sel),
        .mmio_rdata     (mmio_rdata),
        .csr_wen        (csr_wen),
        .csr_addr       (csr_addr),
        .tile_csr_rdata (tile_csr_rdata),
        .mbox_csr_rdata (mbox_csr_rdata),
        .mbox_csr_wen   (mbox_csr_wen),
        .csr_rdata      (csr_rdata)
    );

    // ====================
    // Clock and watchdog
    // ====================
    initial sys_clk = 1'b0;
    always #50 sys_clk = ~sys_clk;

    // Limit is set once the command count is known
    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ====================
    // Compare tasks
    // ====================
    task automatic check_id(input core_id_t got, input core_id_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input xword_t got, input xword_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_mask(input core_mask_t got, input core_mask_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // ====================
    // Command runners
    // ====================
    // One grant on port A, memory acks lat cycles after the request shows up
    task automatic run_tile(input core_mask_t mask, input int lat, input core_id_t exp_win);
        tile_addr_t held;
        core_mask_t one_hot;
        one_hot          = '0;
        one_hot[exp_win] = 1'b1;
        tile_req         = mask;
        while (mem_tile_req !== 1'b1) @(negedge sys_clk);
        check_id(mem_tile_addr[`MP64_CORE_ID_BITS-1:0], exp_win, "tile winner");
        check_word(xword_t'(mem_tile_addr), xword_t'(tile_addr[exp_win]), "port A address");
        check_mask(core_mask_t'(mem_tile_wen), core_mask_t'(tile_wen[exp_win]), "port A wen");
        // Winner's write line, one 64-bit slice at a time
        for (int s = 0; s < `MP64_TILE_DATA_BITS / `MP64_XLEN; s++) begin
            check_word(mem_tile_wdata[s*`MP64_XLEN +: `MP64_XLEN],
                       tile_wdata[exp_win][s*`MP64_XLEN +: `MP64_XLEN], "port A wdata");
        end
        held = mem_tile_addr;
        // Port must hold still for the whole latency
        for (int i = 1; i < lat; i++) begin
            @(negedge sys_clk);
            check_mask(core_mask_t'(mem_tile_req), core_mask_t'(1), "port A request held");
            check_word(xword_t'(mem_tile_addr), xword_t'(held), "port A address held");
            check_mask(tile_ack, '0, "tile_ack before memory ack");
        end
        @(negedge sys_clk);
        mem_tile_ack = 1'b1;
        #10;
        check_mask(tile_ack, one_hot, "tile_ack routing");
        @(negedge sys_clk);
        mem_tile_ack = 1'b0;
        tile_req     = '0;
        // Back in idle after the ack edge
        check_mask(core_mask_t'(mem_tile_req), '0, "port A request after ack");
    endtask

    task automatic run_mmio(input logic req, input mmio_addr_t addr, input byte_t u,
                            input byte_t t, input byte_t d, input byte_t n, input byte_t m,
                            input logic [4:0] exp_sel, input xword_t exp_data);
        mmio_req    = req;
        mmio_addr   = addr;
        uart_rdata  = u;
        timer_rdata = t;
        disk_rdata  = d;
        nic_rdata   = n;
        mbox_rdata  = m;
        #10;
        // Select order in the file is mbox nic disk timer uart
        check_word(xword_t'({mbox_sel, nic_sel, disk_sel, timer_sel, uart_sel}),
                   xword_t'(exp_sel), "peripheral selects");
        check_word(mmio_rdata, exp_data, "mmio_rdata");
    endtask

    task automatic run_csr(input core_id_t core, input csr_addr_t addr, input logic wen,
                           input core_mask_t exp_strobe, input logic from_mbox);
        xword_t exp_data;
        csr_wen        = '0;
        csr_wen[core]  = wen;
        csr_addr[core] = addr;
        #10;
        exp_data = from_mbox ? mbox_csr_rdata[core] : tile_csr_rdata[core];
        check_mask(mbox_csr_wen, exp_strobe, "mbox_csr_wen");
        check_word(csr_rdata[core], exp_data, "csr_rdata");
        csr_wen = '0;
    endtask

    // ====================
    // Command file
    // ====================
    task automatic load_commands();
        int    fd;
        string line;
        fd = $fopen("testbench/fabric_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the command file testbench/fabric_input.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Skip blank and comment lines
            if (line.len() > 1 && line.getc(0) != "#") begin
                cmds.push_back(line);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_command(input string line);
        logic [63:0] fld [9];
        int          n;
        string       rest;
        rest = line.substr(1, line.len() - 1);
        case (line.getc(0))
            "T": begin
                n = $sscanf(rest, "%h %h %h", fld[0], fld[1], fld[2]);
                if (n != 3) begin
                    $display("Badly formed tile command: %s", line);
                    errors++;
                end else begin
                    run_tile(core_mask_t'(fld[0]), int'(fld[1]), core_id_t'(fld[2]));
                end
            end
            "M": begin
                n = $sscanf(rest, "%h %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                            fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]);
                if (n != 9) begin
                    $display("Badly formed peripheral command: %s", line);
                    errors++;
                end else begin
                    run_mmio(fld[0][0], mmio_addr_t'(fld[1]), byte_t'(fld[2]),
                             byte_t'(fld[3]), byte_t'(fld[4]), byte_t'(fld[5]),
                             byte_t'(fld[6]), 5'(fld[7]), fld[8]);
                end
            end
            "C": begin
                n = $sscanf(rest, "%h %h %h %h %h", fld[0], fld[1], fld[2], fld[3], fld[4]);
                if (n != 5) begin
                    $display("Badly formed CSR command: %s", line);
                    errors++;
                end else begin
                    run_csr(core_id_t'(fld[0]), csr_addr_t'(fld[1]), fld[2][0],
                            core_mask_t'(fld[3]), fld[4][0]);
                end
            end
            default: begin
                $display("Unknown command in the input file: %s", line);
                errors++;
            end
        endcase
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        sys_rst_n    = 1'b0;
        tile_req     = '0;
        tile_wen     = 4'b1010;
        mem_tile_ack = 1'b0;
        mmio_req     = 1'b0;
        mmio_addr    = '0;
        uart_rdata   = 8'h00;
        timer_rdata  = 8'h00;
        disk_rdata   = 8'h00;
        nic_rdata    = 8'h00;
        mbox_rdata   = 8'h00;
        csr_wen      = '0;
        // Core ID sits in the low address bits, data differs per lane
        for (int c = 0; c < `MP64_NUM_CORES; c++) begin
            tile_addr[c]      = tile_addr_t'(32'h1000 * (c + 1) + c);
            tile_wdata[c]     = {16{32'(32'hD0D0_0000 + c)}};
            csr_addr[c]       = 8'h00;
            tile_csr_rdata[c] = 64'h7111_0000_0000_0000 + xword_t'(c);
            mbox_csr_rdata[c] = 64'hB0B0_0000_0000_0000 + xword_t'(c);
        end
        load_commands();
        cycle_limit = 40 * (cmds.size() + 2);
        if (cmds.size() == 0) begin
            $display("The command file holds no commands");
            errors++;
        end
        repeat (2) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_rst_n = 1'b1;
        // Reset values of the shared port
        check_mask(core_mask_t'(mem_tile_req), '0, "mem_tile_req after reset");
        check_mask(tile_ack, '0, "tile_ack after reset");
        foreach (cmds[i]) begin
            @(negedge sys_clk);
            run_command(cmds[i]);
        end
        @(negedge sys_clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/fabric_input.txt ====
# T mask latency winner : engines in mask request, memory acks after latency cycles
# M req addr uart timer disk nic mbox sel rdata : sel bits are mbox nic disk timer uart
# C core addr wen strobe src : strobe is the mbox_csr_wen mask, src 1 means mailbox data
T f 3 1
T f 1 2
T f 5 3
T f 2 0
T f 4 1
T 4 2 2
T 4 1 2
T 4 6 2
M 1 004 a1 b2 c3 d4 e5 01 a1
M 1 1f0 a1 b2 c3 d4 e5 02 b2
M 1 2ff a1 b2 c3 d4 e5 04 c3
M 1 410 a1 b2 c3 d4 e5 08 d4
M 1 500 a1 b2 c3 d4 e5 10 e5
M 1 6ff a1 b2 c3 d4 e5 10 e5
M 1 300 a1 b2 c3 d4 e5 00 4d50363400020001
M 1 308 a1 b2 c3 d4 e5 00 100000
M 1 310 a1 b2 c3 d4 e5 00 4
M 1 318 a1 b2 c3 d4 e5 00 0
M 1 700 a1 b2 c3 d4 e5 00 0
M 0 004 a1 b2 c3 d4 e5 00 0
C 0 22 1 1 1
C 1 23 1 2 1
C 2 22 0 0 1
C 3 21 1 0 0
C 2 40 1 0 0
C 3 23 1 8 1

// ==== compile.f ====
+incdir+include
rtl/mp64_pkg.sv
rtl/tile_port_arbiter.sv
rtl/mmio_decoder.sv
rtl/csr_ipi_router.sv
rtl/mp64_fabric.sv
testbench/tb_mp64_fabric.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the interconnect testbench with Verilator, run it from the project root
# and decide the result from the simulation log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mp64_fabric -f compile.f \
    -o sim_fabric > build.log 2>&1 \
    && ./obj_dir/sim_fabric > sim.log 2>&1 \
    || { echo "Build or simulation aborted, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0
